// File: uart_axis_top.f
+incdir+.
axis_pkg.sv
uart_pkg.sv
axis_fifo.sv
axis_uart_tx.sv
axis_uart_rx.sv
uart_axis_top.sv
tb_uart_clk.sv
tb_uart_axis_top.sv

// File: Bender.yml
package:
  name: uart_axis_top

export_include_dirs:
  - .

sources:
  - files:
      - axis_pkg.sv
      - uart_pkg.sv
      - axis_fifo.sv
      - axis_uart_tx.sv
      - axis_uart_rx.sv
      - uart_axis_top.sv
  - target: test
    files:
      - tb_uart_clk.sv
      - tb_uart_axis_top.sv

// File: tb_uart_axis_top.sv
/*
 * Testbench for the UART stream bridge
 * Directed loopback and driven-line tests with typed compare tasks
 */
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_uart_axis_top;
    import axis_pkg::*;

    localparam int BIT_CLKS       = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int FRAME_CLKS     = 10 * BIT_CLKS; // Start, 8 data, stop
    localparam int FRAMES_PLANNED = 15;
    localparam int TIMEOUT_CYCLES = 120 * FRAMES_PLANNED + 200;

    logic          clk;
    logic          arstn;
    logic          s_tx_valid;
    axis_byte_t    s_tx_data;
    logic          s_tx_ready;
    logic          m_rx_valid;
    axis_rx_beat_t m_rx_beat;
    logic          m_rx_ready;
    logic          uart_line;
    logic          uart_tx;
    logic          line_q;
    logic          loopback_en;
    integer        seed;
    int            cycle_cnt;
    int            err_cnt;
    int            fail_cnt;
    logic          full_seen;
    axis_byte_t    exp_q[$];
    axis_rx_beat_t rx_q[$];

    tb_uart_clk #(
        .HALF_PERIOD_NS(50),
        .RESET_CYCLES  (16)
    ) u_clk (
        .clk_o  (clk),
        .arstn_o(arstn)
    );

    assign uart_line = loopback_en ? uart_tx : line_q;

    uart_axis_top u_uart_axis_top (
        .clk_i       (clk),
        .arstn_i     (arstn),
        .s_tx_valid_i(s_tx_valid),
        .s_tx_data_i (s_tx_data),
        .s_tx_ready_o(s_tx_ready),
        .m_rx_valid_o(m_rx_valid),
        .m_rx_beat_o (m_rx_beat),
        .m_rx_ready_i(m_rx_ready),
        .uart_rx_i   (uart_line),
        .uart_tx_o   (uart_tx)
    );

    // Accepted receive beats in arrival order
    always @(negedge clk) begin
        if (arstn && m_rx_valid && m_rx_ready) begin
            rx_q.push_back(m_rx_beat);
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a test did not finish", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_byte(input string name, input axis_byte_t exp,
                              input axis_byte_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_rx_beat(input string name, input axis_rx_beat_t exp,
                                 input axis_rx_beat_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        fail_cnt++;
        $display("%s", msg);
    endtask

    function automatic axis_byte_t rand_byte();
        logic [31:0] r;
        axis_byte_t  b;
        r       = $random(seed);
        b.tdata = r[7:0];
        return b;
    endfunction

    function automatic axis_rx_beat_t make_beat(input axis_byte_t b, input logic fe,
                                                input logic ov);
        axis_rx_beat_t beat;
        beat.tdata     = b.tdata;
        beat.frame_err = fe;
        beat.overrun   = ov;
        return beat;
    endfunction

    // Holds valid until the byte is taken, returns just after that edge
    task automatic push_byte(input axis_byte_t b);
        s_tx_valid = 1'b1;
        s_tx_data  = b;
        @(negedge clk);
        while (!s_tx_ready) begin
            full_seen = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic release_tx();
        s_tx_valid = 1'b0;
    endtask

    task automatic expect_beat(input axis_rx_beat_t exp);
        axis_rx_beat_t act;
        while (rx_q.size() == 0) begin
            @(negedge clk);
        end
        act = rx_q.pop_front();
        check_rx_beat("m_rx_beat_o", exp, act);
        @(posedge clk);
        #1;
    endtask

    // Drives one 8N1 frame on the line register, then one idle bit
    task automatic send_line_frame(input axis_byte_t b, input logic stop_bit);
        int i;
        line_q = 1'b0;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
        for (i = 0; i < `UART_DATA_WIDTH; i++) begin
            line_q = b.tdata[i];
            repeat (BIT_CLKS) @(posedge clk);
            #1;
        end
        line_q = stop_bit;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
        line_q = 1'b1;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
    endtask

    // Samples the transmit line at each mid-bit of the next frame
    task automatic capture_tx_frame(input axis_byte_t exp);
        axis_byte_t got;
        logic       start_bit;
        logic       stop_bit;
        int         i;
        @(negedge clk);
        while (uart_tx !== 1'b0) begin
            @(negedge clk);
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        start_bit = uart_tx;
        for (i = 0; i < `UART_DATA_WIDTH; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            got.tdata[i] = uart_tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        stop_bit = uart_tx;
        check_bit("uart_tx_o start", 1'b0, start_bit);
        check_byte("uart_tx_o data", exp, got);
        check_bit("uart_tx_o stop", 1'b1, stop_bit);
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_bit("uart_tx_o", 1'b1, uart_tx);
        check_bit("s_tx_ready_o", 1'b1, s_tx_ready);
        check_bit("m_rx_valid_o", 1'b0, m_rx_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic test_single_loopback();
        axis_byte_t b;
        b = rand_byte();
        push_byte(b);
        release_tx();
        expect_beat(make_beat(b, 1'b0, 1'b0));
    endtask

    task automatic test_burst_backpressure();
        axis_byte_t b;
        int         i;
        full_seen = 1'b0;
        for (i = 0; i < 8; i++) begin
            b = rand_byte();
            exp_q.push_back(b);
            push_byte(b);
        end
        release_tx();
        if (!full_seen) begin
            note_failure("s_tx_ready_o never went low while the FIFO was full");
        end
        while (exp_q.size() > 0) begin
            expect_beat(make_beat(exp_q.pop_front(), 1'b0, 1'b0));
        end
    endtask

    task automatic test_frame_error();
        axis_byte_t b;
        loopback_en = 1'b0;
        b = rand_byte();
        send_line_frame(b, 1'b0); // Stop bit forced low
        expect_beat(make_beat(b, 1'b1, 1'b0));
        b = rand_byte();
        send_line_frame(b, 1'b1);
        expect_beat(make_beat(b, 1'b0, 1'b0));
    endtask

    task automatic test_overrun();
        axis_byte_t first;
        axis_byte_t second;
        first  = rand_byte();
        second = rand_byte();
        m_rx_ready = 1'b0;
        send_line_frame(first, 1'b1);
        send_line_frame(second, 1'b1);
        @(negedge clk);
        check_bit("m_rx_valid_o", 1'b1, m_rx_valid);
        @(posedge clk);
        #1;
        m_rx_ready = 1'b1;
        expect_beat(make_beat(first, 1'b0, 1'b1));
        repeat (2 * FRAME_CLKS) @(negedge clk);
        if (rx_q.size() != 0 || m_rx_valid) begin
            note_failure("A second receive beat appeared after an overrun");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_line_format();
        axis_byte_t b0;
        axis_byte_t b1;
        loopback_en = 1'b1;
        b0 = rand_byte();
        b1 = rand_byte();
        push_byte(b0);
        push_byte(b1);
        release_tx();
        capture_tx_frame(b0);
        capture_tx_frame(b1);
        expect_beat(make_beat(b0, 1'b0, 1'b0));
        expect_beat(make_beat(b1, 1'b0, 1'b0));
    endtask

    initial begin
        seed        = 32'h766c_c685;
        cycle_cnt   = 0;
        err_cnt     = 0;
        fail_cnt    = 0;
        full_seen   = 1'b0;
        s_tx_valid  = 1'b0;
        s_tx_data   = '0;
        m_rx_ready  = 1'b1;
        line_q      = 1'b1; // Idle line level
        loopback_en = 1'b1;
        @(posedge arstn);
        @(posedge clk);
        #1;
        test_reset_state();
        test_single_loopback();
        test_burst_backpressure();
        test_frame_error();
        test_overrun();
        test_line_format();
        $display("Done: %0d value errors, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb_uart_clk.sv
/*
 * Testbench clock and reset source
 */
`timescale 1ns/1ps

module tb_uart_clk #(
    parameter int HALF_PERIOD_NS = 50,
    parameter int RESET_CYCLES   = 16
) (
    output logic clk_o,
    output logic arstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        arstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arstn_o = 1'b1; // Released just after an edge
    end

endmodule

// File: uart_axis_top.sv
/*
 * UART stream bridge
 * Transmit FIFO and serializer, plus the receive deserializer
 */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_axis_top (
    input  logic                    clk_i,
    input  logic                    arstn_i,
    input  logic                    s_tx_valid_i,
    input  axis_pkg::axis_byte_t    s_tx_data_i,
    output logic                    s_tx_ready_o,
    output logic                    m_rx_valid_o,
    output axis_pkg::axis_rx_beat_t m_rx_beat_o,
    input  logic                    m_rx_ready_i,
    input  logic                    uart_rx_i,
    output logic                    uart_tx_o
);
    import axis_pkg::*;

    logic       fifo_valid;
    axis_byte_t fifo_data;
    logic       fifo_ready;

    axis_fifo #(
        .DEPTH(`UART_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk_i    (clk_i),
        .arstn_i  (arstn_i),
        .s_valid_i(s_tx_valid_i),
        .s_data_i (s_tx_data_i),
        .s_ready_o(s_tx_ready_o),
        .m_valid_o(fifo_valid),
        .m_data_o (fifo_data),
        .m_ready_i(fifo_ready)
    );

    axis_uart_tx #(
        .CLK_FREQ (`UART_CLK_FREQ),
        .BAUD_RATE(`UART_BAUD_RATE)
    ) u_uart_tx (
        .clk_i    (clk_i),
        .arstn_i  (arstn_i),
        .s_valid_i(fifo_valid),
        .s_data_i (fifo_data),
        .s_ready_o(fifo_ready),
        .uart_tx_o(uart_tx_o)
    );

    axis_uart_rx #(
        .CLK_FREQ (`UART_CLK_FREQ),
        .BAUD_RATE(`UART_BAUD_RATE)
    ) u_uart_rx (
        .clk_i    (clk_i),
        .arstn_i  (arstn_i),
        .uart_rx_i(uart_rx_i),
        .m_valid_o(m_rx_valid_o),
        .m_beat_o (m_rx_beat_o),
        .m_ready_i(m_rx_ready_i)
    );

endmodule

// File: axis_uart_rx.sv
/*
 * UART receiver
 * Recovers 8N1 frames into stream beats with frame and overrun flags
 */
`timescale 1ns/1ps
`include "uart_consts.svh"

module axis_uart_rx #(
    parameter int CLK_FREQ  = `UART_CLK_FREQ,
    parameter int BAUD_RATE = `UART_BAUD_RATE
) (
    input  logic                    clk_i,
    input  logic                    arstn_i,
    input  logic                    uart_rx_i,
    output logic                    m_valid_o,
    output axis_pkg::axis_rx_beat_t m_beat_o,
    input  logic                    m_ready_i
);
    import axis_pkg::*;
    import uart_pkg::*;

    localparam int DIVIDER = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W   = (DIVIDER > 1) ? $clog2(DIVIDER) : 1;
    localparam int BIT_W   = $clog2(`UART_DATA_WIDTH);
    localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(DIVIDER - 1);
    localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(DIVIDER / 2 - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(`UART_DATA_WIDTH - 1);

    uart_rx_state_t              state_q;
    logic [1:0]                  sync_q;
    logic                        rx_prev_q;
    logic                        rx_s;
    logic                        start_edge;
    logic [CNT_W-1:0]            baud_cnt;
    logic                        baud_tick;
    logic [BIT_W-1:0]            bit_cnt;
    logic [`UART_DATA_WIDTH-1:0] shift_q;
    logic                        frame_done;
    axis_rx_beat_t               beat_q;

    assign rx_s       = sync_q[1];
    assign start_edge = rx_prev_q & ~rx_s;
    assign baud_tick  = (state_q != RX_IDLE) && (baud_cnt == '0); // Mid-bit sample point
    assign frame_done = (state_q == RX_STOP) && baud_tick;
    assign m_beat_o   = beat_q;

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            sync_q    <= 2'b11;
            rx_prev_q <= 1'b1;
        end else begin
            sync_q    <= {sync_q[0], uart_rx_i};
            rx_prev_q <= rx_s;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q <= RX_IDLE;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    if (start_edge) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_tick) begin
                        state_q <= rx_s ? RX_IDLE : RX_DATA; // High here is a glitch
                    end
                end
                RX_DATA: begin
                    if (baud_tick && (bit_cnt == BIT_LAST)) begin
                        state_q <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (baud_tick) begin
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Half bit after the edge, then whole bits
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if (state_q == RX_IDLE) begin
            baud_cnt <= HALF_LOAD;
        end else if (baud_tick) begin
            baud_cnt <= FULL_LOAD;
        end else begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state_q == RX_IDLE) begin
            bit_cnt <= '0;
        end else if ((state_q == RX_DATA) && baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == RX_DATA) && baud_tick) begin
            shift_q <= {rx_s, shift_q[`UART_DATA_WIDTH-1:1]}; // LSB arrives first
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            m_valid_o <= 1'b0;
        end else if (frame_done) begin
            m_valid_o <= 1'b1;
        end else if (m_ready_i) begin
            m_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (frame_done) begin
            if (!m_valid_o || m_ready_i) begin
                beat_q.tdata     <= shift_q;
                beat_q.frame_err <= ~rx_s;
                beat_q.overrun   <= 1'b0;
            end else begin
                beat_q.overrun   <= 1'b1; // Unread beat kept, new byte lost
            end
        end
    end

endmodule

// File: axis_uart_tx.sv
/*
 * UART transmitter
 * Serializes accepted stream bytes into 8N1 frames, LSB first
 */
`timescale 1ns/1ps
`include "uart_consts.svh"

module axis_uart_tx #(
    parameter int CLK_FREQ  = `UART_CLK_FREQ,
    parameter int BAUD_RATE = `UART_BAUD_RATE
) (
    input  logic                 clk_i,
    input  logic                 arstn_i,
    input  logic                 s_valid_i,
    input  axis_pkg::axis_byte_t s_data_i,
    output logic                 s_ready_o,
    output logic                 uart_tx_o
);
    import axis_pkg::*;
    import uart_pkg::*;

    localparam int DIVIDER = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W   = (DIVIDER > 1) ? $clog2(DIVIDER) : 1;
    localparam int BIT_W   = $clog2(`UART_DATA_WIDTH);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(DIVIDER - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(`UART_DATA_WIDTH - 1);

    uart_tx_state_t   state_q;
    logic [CNT_W-1:0] baud_cnt;
    logic [BIT_W-1:0] bit_cnt;
    axis_byte_t       tx_data_q;
    logic             tx_fire;
    logic             baud_done;
    logic             bit_done;
    logic             in_frame;

    assign s_ready_o = (state_q == TX_IDLE);
    assign tx_fire   = s_valid_i & s_ready_o;
    assign in_frame  = (state_q == TX_START) || (state_q == TX_DATA) || (state_q == TX_STOP);
    assign baud_done = (baud_cnt == BAUD_LAST);
    assign bit_done  = (bit_cnt == BIT_LAST) && baud_done; // Last data bit fully sent

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q   <= TX_IDLE;
            uart_tx_o <= 1'b1; // Line idles high
        end else begin
            case (state_q)
                TX_IDLE: begin
                    uart_tx_o <= 1'b1;
                    if (tx_fire) begin
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    uart_tx_o <= 1'b0;
                    if (baud_done) begin
                        state_q <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    uart_tx_o <= tx_data_q.tdata[bit_cnt];
                    if (bit_done) begin
                        state_q <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    uart_tx_o <= 1'b1;
                    if (baud_done) begin
                        state_q <= TX_WAIT;
                    end
                end
                TX_WAIT: begin
                    uart_tx_o <= 1'b1;
                    state_q   <= TX_IDLE;
                end
                default: begin
                    uart_tx_o <= 1'b1;
                    state_q   <= TX_IDLE;
                end
            endcase
        end
    end

    // Bit period timer
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if (baud_done || !in_frame) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (bit_done) begin
            bit_cnt <= '0;
        end else if ((state_q == TX_DATA) && baud_done) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_fire) begin
            tx_data_q <= s_data_i;
        end
    end

endmodule

// File: axis_fifo.sv
/*
 * Stream FIFO
 * Circular buffer with valid/ready on both sides
 */
`timescale 1ns/1ps
`include "uart_consts.svh"

module axis_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                clk_i,
    input  logic                arstn_i,
    input  logic                s_valid_i,
    input  axis_pkg::axis_byte_t s_data_i,
    output logic                s_ready_o,
    output logic                m_valid_o,
    output axis_pkg::axis_byte_t m_data_o,
    input  logic                m_ready_i
);
    import axis_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    axis_byte_t       mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign s_ready_o = (count_q != CNT_FULL);
    assign m_valid_o = (count_q != '0);
    assign m_data_o  = mem_q[rd_ptr_q]; // Oldest entry
    assign push      = s_valid_i & s_ready_o;
    assign pop       = m_valid_o & m_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= s_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // Both or neither
            endcase
        end
    end

endmodule

// File: uart_pkg.sv
/*
 * UART frame state types
 * State encodings for the 8N1 transmitter and receiver
 */
package uart_pkg;

    // Transmitter frame walk
    typedef enum logic [2:0] {
        TX_IDLE  = 3'b000,
        TX_START = 3'b001,
        TX_DATA  = 3'b010,
        TX_STOP  = 3'b011,
        TX_WAIT  = 3'b100  // One spacer cycle before the next byte
    } uart_tx_state_t;

    // Receiver frame walk
    typedef enum logic [2:0] {
        RX_IDLE  = 3'b000,
        RX_START = 3'b001, // Half bit to the start mid-point
        RX_DATA  = 3'b010,
        RX_STOP  = 3'b011
    } uart_rx_state_t;

endpackage

// File: axis_pkg.sv
/*
 * Stream beat types
 * Payloads carried on the transmit and receive byte streams
 */
`include "uart_consts.svh"

package axis_pkg;

    // Transmit stream payload
    typedef struct packed {
        logic [`UART_DATA_WIDTH-1:0] tdata;
    } axis_byte_t;

    // Receive stream payload with line status
    typedef struct packed {
        logic [`UART_DATA_WIDTH-1:0] tdata;
        logic                        frame_err; // Stop bit sampled low
        logic                        overrun;   // Later frame lost
    } axis_rx_beat_t;

endpackage

// File: uart_consts.svh
/*
 * UART bridge constants
 * Clock, line rate, character size and transmit buffer depth
 */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// System clock in Hz
`define UART_CLK_FREQ 10_000_000

// Line rate, gives 10 clocks per bit
`define UART_BAUD_RATE 1_000_000

`define UART_DATA_WIDTH 8 // Bits per character

`define UART_FIFO_DEPTH 4 // Transmit FIFO entries

`endif
